// ==== design/rv_pkg.sv ====
package rv_pkg;

  // datapath widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;
  localparam logic [XLEN-1:0] RESET_PC = 32'd0;

  // funct7 forms, alt selects SUB / SRA / SRAI
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // ecall has every bit above the opcode clear
  localparam logic [24:0] ECALL_FIELD = 25'd0;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // word width for LW / SW
  localparam logic [2:0] F3_WORD = 3'b010;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } branch_op_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_U} imm_sel_e;
  typedef enum logic {A_RS1, A_ZERO} a_sel_e;
  typedef enum logic {B_RS2, B_IMM} b_sel_e;
  typedef enum logic {WB_ALU, WB_LOAD} wb_sel_e;

endpackage

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [XLEN-1:0]       i_insn,
  output logic [REG_ADDR_W-1:0] o_rs1,
  output logic [REG_ADDR_W-1:0] o_rs2,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic                  o_rf_we,
  output alu_op_e               o_alu_op,
  output a_sel_e                o_a_sel,
  output b_sel_e                o_b_sel,
  output imm_sel_e              o_imm_sel,
  output wb_sel_e               o_wb_sel,
  output branch_op_e            o_branch_op,
  output logic                  o_dmem_we,
  output logic                  o_halt
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       funct7_base;
  logic       funct7_alt;
  logic       imm_ok;
  logic       reg_ok;
  alu_op_e    alu_base;
  logic       rf_we;
  logic       dmem_we;
  logic       halt;

  assign opcode = opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  assign funct7_base = (funct7 == FUNCT7_BASE);
  assign funct7_alt  = (funct7 == FUNCT7_ALT);

  // shift immediates carry a funct7 that must be checked
  assign imm_ok = (funct3 != F3_SLL && funct3 != F3_SRL_SRA) || funct7_base ||
                  (funct3 == F3_SRL_SRA && funct7_alt);
  assign reg_ok = funct7_base ||
                  (funct7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

  // alu op shared by OP and OP-IMM, SUB patched in below
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_base = ALU_ADD;
      F3_SLL:     alu_base = ALU_SLL;
      F3_SLT:     alu_base = ALU_SLT;
      F3_SLTU:    alu_base = ALU_SLTU;
      F3_XOR:     alu_base = ALU_XOR;
      F3_SRL_SRA: alu_base = funct7_alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_base = ALU_OR;
      F3_AND:     alu_base = ALU_AND;
      default:    alu_base = ALU_ADD;
    endcase
  end

  always_comb begin
    rf_we       = 1'b0;
    dmem_we     = 1'b0;
    halt        = 1'b0;
    o_alu_op    = ALU_ADD;
    o_a_sel     = A_RS1;
    o_b_sel     = B_IMM;
    o_imm_sel   = IMM_I;
    o_wb_sel    = WB_ALU;
    o_branch_op = BR_NONE;
    case (opcode)
      OP_LUI: begin
        // zero plus the U immediate
        rf_we     = 1'b1;
        o_a_sel   = A_ZERO;
        o_imm_sel = IMM_U;
      end
      OP_IMM: begin
        rf_we    = imm_ok;
        o_alu_op = alu_base;
      end
      OP_REG: begin
        rf_we    = reg_ok;
        o_b_sel  = B_RS2;
        o_alu_op = (funct3 == F3_ADD_SUB && funct7_alt) ? ALU_SUB : alu_base;
      end
      OP_BRANCH: begin
        o_b_sel   = B_RS2;
        o_imm_sel = IMM_B;
        case (funct3)
          F3_BEQ:  o_branch_op = BR_BEQ;
          F3_BNE:  o_branch_op = BR_BNE;
          F3_BLT:  o_branch_op = BR_BLT;
          F3_BGE:  o_branch_op = BR_BGE;
          F3_BLTU: o_branch_op = BR_BLTU;
          F3_BGEU: o_branch_op = BR_BGEU;
          default: o_branch_op = BR_NONE;
        endcase
      end
      OP_LOAD: begin
        rf_we    = (funct3 == F3_WORD);
        o_wb_sel = WB_LOAD;
      end
      OP_STORE: begin
        dmem_we   = (funct3 == F3_WORD);
        o_imm_sel = IMM_S;
      end
      OP_SYSTEM: begin
        halt = (i_insn[31:7] == ECALL_FIELD);
      end
      default: begin
        // unknown encodings fall through as a no-op
      end
    endcase
  end

  // strobes held off while in reset
  assign o_rf_we   = rf_we & ~rst;
  assign o_dmem_we = dmem_we & ~rst;
  assign o_halt    = halt & ~rst;

  // one instruction never writes both the register file and memory
  a_single_write: assert property (@(posedge clk) !(o_rf_we && o_dmem_we));

endmodule

// ==== design/rv_imm_gen.sv ====
`timescale 1ns/1ps

module rv_imm_gen import rv_pkg::*; (
  input  logic [XLEN-1:0] i_insn,
  input  imm_sel_e        i_imm_sel,
  output logic [XLEN-1:0] o_imm
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;

  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};

  // branch offsets are in halfwords, bit 0 always clear
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                  i_insn[11:8], 1'b0};

  assign imm_u = {i_insn[31:12], 12'b0};

  always_comb begin
    case (i_imm_sel)
      IMM_I:   o_imm = imm_i;
      IMM_S:   o_imm = imm_s;
      IMM_B:   o_imm = imm_b;
      IMM_U:   o_imm = imm_u;
      default: o_imm = imm_i;
    endcase
  end

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] i_rs1,
  input  logic [REG_ADDR_W-1:0] i_rs2,
  input  logic [REG_ADDR_W-1:0] i_rd,
  input  logic                  i_we,
  input  logic [XLEN-1:0]       i_rd_data,
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 is cleared here and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  a_x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
    (i_rs1 == '0) |-> (o_rs1_data == '0));
  a_x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
    (i_rs2 == '0) |-> (o_rs2_data == '0));

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_imm,
  input  logic [XLEN-1:0] i_load_data,
  input  alu_op_e         i_alu_op,
  input  a_sel_e          i_a_sel,
  input  b_sel_e          i_b_sel,
  input  wb_sel_e         i_wb_sel,
  output logic [XLEN-1:0] o_rd_data,
  output logic [XLEN-1:0] o_dmem_addr
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_result;

  assign op_a  = (i_a_sel == A_ZERO) ? '0 : i_rs1_data;
  assign op_b  = (i_b_sel == B_IMM) ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = op_a + op_b;
    endcase
  end

  // loads and stores both use rs1 + imm from the adder
  assign o_dmem_addr = alu_result;

  assign o_rd_data = (i_wb_sel == WB_LOAD) ? i_load_data : alu_result;

  // word loads must land on a word boundary
  always_comb begin
    if (i_wb_sel == WB_LOAD) begin
      a_load_aligned: assert (o_dmem_addr[1:0] == 2'b00);
    end
  end

endmodule

// ==== design/rv_pc_unit.sv ====
`timescale 1ns/1ps

module rv_pc_unit import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  branch_op_e      i_branch_op,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_imm,
  input  logic            i_halt,
  output logic [XLEN-1:0] o_pc
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            taken;
  logic [XLEN-1:0] pc_next;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_branch_op)
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = ~eq;
      BR_BLT:  taken = lt_s;
      BR_BGE:  taken = ~lt_s;
      BR_BLTU: taken = lt_u;
      BR_BGEU: taken = ~lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign pc_next = taken ? (o_pc + i_imm) : (o_pc + PC_STEP);

  // halted core keeps fetching the ecall
  always_ff @(posedge clk) begin
    if (rst) begin
      o_pc <= RESET_PC;
    end else if (!i_halt) begin
      o_pc <= pc_next;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00);

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  output logic [XLEN-1:0] o_imem_addr,
  input  logic [XLEN-1:0] i_imem_data,
  output logic [XLEN-1:0] o_dmem_addr,
  output logic [XLEN-1:0] o_dmem_wdata,
  output logic            o_dmem_we,
  input  logic [XLEN-1:0] i_dmem_rdata,
  output logic            o_halt
);

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rf_we;
  alu_op_e               alu_op;
  a_sel_e                a_sel;
  b_sel_e                b_sel;
  imm_sel_e              imm_sel;
  wb_sel_e               wb_sel;
  branch_op_e            branch_op;
  logic                  halt;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       rd_data;

  rv_decoder u_decoder (
    .clk         (clk),
    .rst         (rst),
    .i_insn      (i_imem_data),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_rf_we     (rf_we),
    .o_alu_op    (alu_op),
    .o_a_sel     (a_sel),
    .o_b_sel     (b_sel),
    .o_imm_sel   (imm_sel),
    .o_wb_sel    (wb_sel),
    .o_branch_op (branch_op),
    .o_dmem_we   (o_dmem_we),
    .o_halt      (halt)
  );

  rv_imm_gen u_imm_gen (
    .i_insn    (i_imem_data),
    .i_imm_sel (imm_sel),
    .o_imm     (imm)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rf_we),
    .i_rd_data  (rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (imm),
    .i_load_data (i_dmem_rdata),
    .i_alu_op    (alu_op),
    .i_a_sel     (a_sel),
    .i_b_sel     (b_sel),
    .i_wb_sel    (wb_sel),
    .o_rd_data   (rd_data),
    .o_dmem_addr (o_dmem_addr)
  );

  rv_pc_unit u_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .i_branch_op (branch_op),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (imm),
    .i_halt      (halt),
    .o_pc        (o_imem_addr)
  );

  // store data is rs2 straight from the register file
  assign o_dmem_wdata = rs2_data;
  assign o_halt       = halt;

endmodule

// ==== bench/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// fibonacci lfsr with taps 16 14 13 11, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  int          k;
  r = '0;
  for (k = 0; k < n; k++) begin
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    r          = {r[30:0], fb};
  end
  return r;
endfunction

// data memory contents after reset, a function of the full address
function automatic logic [31:0] fill_word(input int k);
  return ((32'(k) << 2) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, OP_LUI};
endfunction

task automatic emit(input logic [31:0] insn);
  imem[emit_idx[7:0]] = insn;
  emit_idx++;
endtask

// branch over an increment of x21, so x21 counts the fall-throughs
task automatic branch_pair(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2);
  emit(enc_b(13'd8, rs2, rs1, f3));
  emit(enc_i(12'd1, 5'd21, F3_ADD_SUB, 5'd21, OP_IMM));
endtask

task automatic build_program();
  logic [4:0]  pair_a [4];
  logic [4:0]  pair_b [4];
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] imm;
  int          k;
  int          p;
  pair_a   = '{5'd17, 5'd18, 5'd19, 5'd1};
  pair_b   = '{5'd18, 5'd19, 5'd17, 5'd2};
  emit_idx = 0;
  for (k = 0; k < IMEM_WORDS; k++) begin
    imem[k[7:0]] = {ECALL_FIELD, OP_SYSTEM};
  end
  // random values in x1..x8
  for (k = 1; k <= 8; k++) begin
    emit(enc_u(20'(rand_bits(20)), 5'(k)));
    emit(enc_i(12'(rand_bits(12)), 5'(k), F3_ADD_SUB, 5'(k), OP_IMM));
  end
  // remaining immediate ops into x9..x15, srai into x16
  for (k = 1; k <= 7; k++) begin
    f3 = 3'(k);
    if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
      imm = {FUNCT7_BASE, 5'(rand_bits(5))};
    end else begin
      imm = 12'(rand_bits(12));
    end
    emit(enc_i(imm, 5'(k), f3, 5'(k + 8), OP_IMM));
  end
  emit(enc_i({FUNCT7_ALT, 5'(rand_bits(5))}, 5'd8, F3_SRL_SRA, 5'd16, OP_IMM));
  for (k = 1; k <= 16; k++) begin
    emit(enc_s(12'(4 * k), 5'(k), 5'd0));
  end
  // extremes: x17 = most negative, x18 = all ones, x19 = one
  emit(enc_u(20'h80000, 5'd17));
  emit(enc_i(12'hfff, 5'd0, F3_ADD_SUB, 5'd18, OP_IMM));
  emit(enc_i(12'h001, 5'd0, F3_ADD_SUB, 5'd19, OP_IMM));
  for (p = 0; p < 4; p++) begin
    for (k = 0; k < 10; k++) begin
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD_SUB : F3_SRL_SRA);
      f7 = (k < 8) ? FUNCT7_BASE : FUNCT7_ALT;
      emit(enc_r(f7, pair_b[p[1:0]], pair_a[p[1:0]], f3, 5'd20));
      emit(enc_s(12'(128 + 4 * k), 5'd20, 5'd0));
    end
  end
  // taken first, then not taken
  branch_pair(F3_BEQ, 5'd18, 5'd18);
  branch_pair(F3_BEQ, 5'd18, 5'd19);
  branch_pair(F3_BNE, 5'd18, 5'd19);
  branch_pair(F3_BNE, 5'd18, 5'd18);
  branch_pair(F3_BLT, 5'd18, 5'd19);
  branch_pair(F3_BLT, 5'd19, 5'd18);
  branch_pair(F3_BGE, 5'd19, 5'd18);
  branch_pair(F3_BGE, 5'd18, 5'd19);
  branch_pair(F3_BLTU, 5'd19, 5'd18);
  branch_pair(F3_BLTU, 5'd18, 5'd19);
  branch_pair(F3_BGEU, 5'd18, 5'd19);
  branch_pair(F3_BGEU, 5'd19, 5'd18);
  emit(enc_s(12'd192, 5'd21, 5'd0));
  // word 1 was stored above, word 60 still holds its fill value
  emit(enc_i(12'd4, 5'd0, F3_WORD, 5'd22, OP_LOAD));
  emit(enc_s(12'd196, 5'd22, 5'd0));
  emit(enc_i(12'd240, 5'd0, F3_WORD, 5'd23, OP_LOAD));
  emit(enc_s(12'd200, 5'd23, 5'd0));
  emit(enc_i(12'd8, 5'd0, F3_WORD, 5'd0, OP_LOAD));
  emit(enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd0, OP_IMM));
  emit(enc_s(12'd204, 5'd0, 5'd0));
  emit({ECALL_FIELD, OP_SYSTEM});
  prog_len = emit_idx;
endtask

// integer op as the ISA defines it, alt selects sub or arithmetic shift
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    F3_ADD_SUB: return alt ? (a - b) : (a + b);
    F3_SLL:     return a << b[4:0];
    F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
    F3_XOR:     return a ^ b;
    F3_SRL_SRA: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    F3_OR:      return a | b;
    default:    return a & b;
  endcase
endfunction

// what the current instruction at ref_pc does
task automatic model_eval(output logic we, output logic halt, output logic [31:0] addr,
                          output logic [31:0] wdata, output logic wb_en,
                          output logic [4:0] wb_rd, output logic [31:0] wb_val,
                          output logic [31:0] next_pc);
  logic [31:0] insn;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [2:0]  f3;
  logic        take;
  insn    = imem[ref_pc[9:2]];
  f3      = insn[14:12];
  a       = ref_regs[insn[19:15]];
  b       = ref_regs[insn[24:20]];
  imm_i   = {{20{insn[31]}}, insn[31:20]};
  imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  we      = 1'b0;
  halt    = 1'b0;
  addr    = '0;
  wdata   = b;
  wb_en   = 1'b0;
  wb_rd   = insn[11:7];
  wb_val  = '0;
  next_pc = ref_pc + 32'd4;
  take    = 1'b0;
  case (insn[6:0])
    OP_LUI: begin
      wb_en  = 1'b1;
      wb_val = {insn[31:12], 12'd0};
    end
    OP_IMM: begin
      wb_en  = 1'b1;
      wb_val = alu_ref(f3, f3 == F3_SRL_SRA && insn[30], a, imm_i);
    end
    OP_REG: begin
      wb_en  = 1'b1;
      wb_val = alu_ref(f3, insn[30], a, b);
    end
    OP_BRANCH: begin
      case (f3)
        F3_BEQ:  take = (a == b);
        F3_BNE:  take = (a != b);
        F3_BLT:  take = ($signed(a) < $signed(b));
        F3_BGE:  take = ($signed(a) >= $signed(b));
        F3_BLTU: take = (a < b);
        F3_BGEU: take = (a >= b);
        default: take = 1'b0;
      endcase
      if (take) begin
        next_pc = ref_pc + imm_b;
      end
    end
    OP_LOAD: begin
      wb_en  = 1'b1;
      addr   = a + imm_i;
      wb_val = ref_dmem[addr[7:2]];
    end
    OP_STORE: begin
      we   = 1'b1;
      addr = a + imm_s;
    end
    OP_SYSTEM: begin
      if (insn[31:7] == ECALL_FIELD) begin
        halt    = 1'b1;
        next_pc = ref_pc;
      end
    end
    default: begin
    end
  endcase
endtask

`endif

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 5;
  localparam int HALT_CYCLES  = 4;
  localparam int IMEM_WORDS   = 256;
  localparam int DMEM_WORDS   = 64;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] imem_addr;
  logic [XLEN-1:0] imem_data;
  logic [XLEN-1:0] dmem_addr;
  logic [XLEN-1:0] dmem_wdata;
  logic            dmem_we;
  logic [XLEN-1:0] dmem_rdata;
  logic            halt;

  // memories seen by the DUT, then the lockstep model's own state
  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] ref_dmem [DMEM_WORDS];
  logic [31:0] ref_regs [NUM_REGS];
  logic [31:0] ref_pc;
  logic [15:0] lfsr_state;
  int          emit_idx;
  int          prog_len;

  `include "rv_ref_model.svh"

  rv_core UUT (
    .clk          (clk),
    .rst          (rst),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata),
    .o_halt       (halt)
  );

  // both memories answer within the cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  task automatic value_error(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
    $display("Regression failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // model and DUT memory both advance on the rising edge
  always @(posedge clk) begin : lockstep
    logic        we;
    logic        hlt;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] wb_val;
    logic [31:0] next_pc;
    int          i;
    if (rst) begin
      ref_pc = RESET_PC;
      for (i = 0; i < NUM_REGS; i++) begin
        ref_regs[i[4:0]] = '0;
      end
      for (i = 0; i < DMEM_WORDS; i++) begin
        ref_dmem[i[5:0]] = fill_word(i);
        dmem[i[5:0]]    <= fill_word(i);
      end
    end else begin
      model_eval(we, hlt, addr, wdata, wb_en, wb_rd, wb_val, next_pc);
      if (wb_en && wb_rd != 5'd0) begin
        ref_regs[wb_rd] = wb_val;
      end
      if (we) begin
        ref_dmem[addr[7:2]] = wdata;
      end
      ref_pc = next_pc;
      if (dmem_we) begin
        dmem[dmem_addr[7:2]] <= dmem_wdata;
      end
    end
  end

  // outputs are settled mid-cycle
  always @(negedge clk) begin : check_ports
    logic        we;
    logic        hlt;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] wb_val;
    logic [31:0] next_pc;
    if (rst) begin
      a_rst_we: assert (dmem_we === 1'b0)
        else value_error("o_dmem_we", 32'd0, 32'(dmem_we));
      a_rst_halt: assert (halt === 1'b0)
        else value_error("o_halt", 32'd0, 32'(halt));
    end else begin
      model_eval(we, hlt, addr, wdata, wb_en, wb_rd, wb_val, next_pc);
      a_pc: assert (imem_addr === ref_pc)
        else value_error("o_imem_addr", ref_pc, imem_addr);
      a_we: assert (dmem_we === we)
        else value_error("o_dmem_we", 32'(we), 32'(dmem_we));
      a_halt: assert (halt === hlt)
        else value_error("o_halt", 32'(hlt), 32'(halt));
      if (we) begin
        a_addr: assert (dmem_addr === addr)
          else value_error("o_dmem_addr", addr, dmem_addr);
        a_wdata: assert (dmem_wdata === wdata)
          else value_error("o_dmem_wdata", wdata, dmem_wdata);
      end
    end
  end

  initial begin
    rst        = 1'b1;
    lfsr_state = 16'd375;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    while (halt !== 1'b1) begin
      @(posedge clk);
    end
    // keep checking while the core sits on the ecall
    repeat (HALT_CYCLES) @(posedge clk);
    $display("Regression passed");
    $finish;
  end

  initial begin
    wait (prog_len > 0);
    #((prog_len + 20 + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: the core never halted");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== sources.f ====
+incdir+bench
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_imm_gen.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_pc_unit.sv
design/rv_core.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the rv_core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module rv_core_tb -o rv_core_sim; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/rv_core_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
  exit 0
else
  exit 1
fi
